// ==== logic/realign_config.svh ====
`ifndef REALIGN_CONFIG_SVH
`define REALIGN_CONFIG_SVH

// width of the instruction addresses carried with every output slot
`define REALIGN_ADDR_WIDTH 32

// width of one fetch word
// only a 32-bit fetch path is handled, so a word holds two halfword parcels
`define REALIGN_FETCH_WIDTH 32

// width of an output instruction, compressed ones are zero-extended to it
`define REALIGN_INSTR_WIDTH 32

// number of entries in the downstream instruction queue
// a fetch word can yield two instructions, so this must be 2 or more
`define REALIGN_NUM_CREDITS 4

`endif

// ==== logic/realign_pkg.sv ====
`default_nettype none

`include "realign_config.svh"

package realign_pkg;

    // alignment state, HOLD_UPPER means a lower half of a 32-bit instruction waits in the register
    typedef enum logic {
        REALIGN_ALIGNED    = 1'b0,
        REALIGN_HOLD_UPPER = 1'b1
    } align_state_e;

    // what the assembler puts into output slot 0
    typedef enum logic [1:0] {
        SLOT_FULL_WORD = 2'b00,
        SLOT_LOW_RVC   = 2'b01,
        SLOT_HIGH_RVC  = 2'b10,
        SLOT_JOIN_HELD = 2'b11
    } slot_sel_e;

    typedef logic [`REALIGN_FETCH_WIDTH-1:0] fetch_word_t;
    typedef logic [15:0]                     parcel_t;
    typedef logic [`REALIGN_INSTR_WIDTH-1:0] instr_t;
    typedef logic [`REALIGN_ADDR_WIDTH-1:0]  addr_t;

    // free entries in the instruction queue, 0 up to REALIGN_NUM_CREDITS inclusive
    typedef logic [$clog2(`REALIGN_NUM_CREDITS+1)-1:0] credit_t;

endpackage

`default_nettype wire

// ==== logic/parcel_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module parcel_decode (
    input  realign_pkg::fetch_word_t fetch_data_i,
    output realign_pkg::parcel_t     parcel_lo_o,
    output realign_pkg::parcel_t     parcel_hi_o,
    output logic                     lo_is_rvc_o,
    output logic                     hi_is_rvc_o
);

    // ----------------------------------------------------------------------
    // parcel split
    // ----------------------------------------------------------------------

    // p0 sits at the word address, p1 at word address plus 2
    realign_pkg::parcel_t parcel_lo;
    realign_pkg::parcel_t parcel_hi;

    assign parcel_lo = fetch_data_i[15:0];
    assign parcel_hi = fetch_data_i[31:16];

    assign parcel_lo_o = parcel_lo;
    assign parcel_hi_o = parcel_hi;

    // ----------------------------------------------------------------------
    // compressed detection
    // ----------------------------------------------------------------------

    // a 32-bit instruction always has both opcode low bits set
    // any other pattern in bits 1:0 marks a 16-bit compressed instruction
    // when the parcel is an upper half of a straddling instruction the flag is
    // meaningless, and the control block ignores it in that case
    always_comb begin
        lo_is_rvc_o = ~&parcel_lo[1:0];
        hi_is_rvc_o = ~&parcel_hi[1:0];
    end

endmodule

`default_nettype wire

// ==== logic/credit_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "realign_config.svh"

module credit_counter (
    input  logic clk_i,
    input  logic reset_i,
    input  logic consume0_i,
    input  logic consume1_i,
    input  logic credit_i,
    output logic credit_ok_o
);

    localparam realign_pkg::credit_t MAX_CREDITS = `REALIGN_NUM_CREDITS;

    // one bit wider than the count so the sum cannot wrap before saturation
    localparam int unsigned SUM_W = $bits(realign_pkg::credit_t) + 1;

    realign_pkg::credit_t count_q;
    logic [SUM_W-1:0]     count_sum;
    logic [1:0]           consumed;

    // every emitted instruction takes one queue entry
    assign consumed = {1'b0, consume0_i} + {1'b0, consume1_i};

    // issue and return land in the same update, so a returned credit is never lost
    // consumption is bounded by credit_ok_o, so the subtraction cannot underflow
    assign count_sum = SUM_W'(count_q) + SUM_W'(credit_i) - SUM_W'(consumed);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_q <= MAX_CREDITS;
        end else if (count_sum > SUM_W'(MAX_CREDITS)) begin
            // a spurious return would otherwise overstate the queue room
            count_q <= MAX_CREDITS;
        end else begin
            count_q <= realign_pkg::credit_t'(count_sum);
        end
    end

    // a fetch word can produce two instructions, so two entries must be free
    assign credit_ok_o = (count_q >= realign_pkg::credit_t'(2));

endmodule

`default_nettype wire

// ==== logic/realign_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module realign_ctrl (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  logic                   flush_i,
    input  logic                   fetch_valid_i,
    input  logic                   fetch_addr_hi_half_i,
    input  logic                   lo_is_rvc_i,
    input  logic                   hi_is_rvc_i,
    input  logic                   credit_ok_i,
    output logic                   fetch_ready_o,
    output logic                   accept_o,
    output logic                   emit0_o,
    output logic                   emit1_o,
    output logic                   hold_load_o,
    output realign_pkg::slot_sel_e slot0_sel_o,
    output logic                   serving_unaligned_o
);

    realign_pkg::align_state_e state_q;
    realign_pkg::align_state_e state_d;

    // raw decisions for the presented word, before acceptance
    logic emit0;
    logic emit1;
    logic hold_upper;
    logic accept;

    // ----------------------------------------------------------------------
    // handshake
    // ----------------------------------------------------------------------

    // a flush cycle takes nothing, the word stays at the input
    assign fetch_ready_o = credit_ok_i && !flush_i;
    assign accept        = fetch_valid_i && fetch_ready_o;
    assign accept_o      = accept;

    // ----------------------------------------------------------------------
    // alignment decode
    // ----------------------------------------------------------------------

    always_comb begin
        slot0_sel_o = realign_pkg::SLOT_FULL_WORD;
        emit0       = 1'b0;
        emit1       = 1'b0;
        hold_upper  = 1'b0;
        case (state_q)
            realign_pkg::REALIGN_HOLD_UPPER: begin
                // p0 finishes the held instruction, then p1 stands on its own
                slot0_sel_o = realign_pkg::SLOT_JOIN_HELD;
                emit0       = 1'b1;
                emit1       = hi_is_rvc_i;
                hold_upper  = !hi_is_rvc_i;
            end
            default: begin
                if (fetch_addr_hi_half_i) begin
                    // jumped into the upper half, p0 is not part of the stream
                    slot0_sel_o = realign_pkg::SLOT_HIGH_RVC;
                    emit0       = hi_is_rvc_i;
                    hold_upper  = !hi_is_rvc_i;
                end else if (!lo_is_rvc_i) begin
                    slot0_sel_o = realign_pkg::SLOT_FULL_WORD;
                    emit0       = 1'b1;
                end else begin
                    slot0_sel_o = realign_pkg::SLOT_LOW_RVC;
                    emit0       = 1'b1;
                    emit1       = hi_is_rvc_i;
                    hold_upper  = !hi_is_rvc_i;
                end
            end
        endcase
    end

    // nothing moves unless the word is really taken
    assign emit0_o     = accept && emit0;
    assign emit1_o     = accept && emit1;
    assign hold_load_o = accept && hold_upper;

    // ----------------------------------------------------------------------
    // state register
    // ----------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        if (flush_i) begin
            // the held half belongs to the discarded path
            state_d = realign_pkg::REALIGN_ALIGNED;
        end else if (accept) begin
            state_d = hold_upper ? realign_pkg::REALIGN_HOLD_UPPER
                                 : realign_pkg::REALIGN_ALIGNED;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= realign_pkg::REALIGN_ALIGNED;
        end else begin
            state_q <= state_d;
        end
    end

    assign serving_unaligned_o = (state_q == realign_pkg::REALIGN_HOLD_UPPER);

endmodule

`default_nettype wire

// ==== logic/instr_assemble.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "realign_config.svh"

module instr_assemble (
    input  logic                      clk_i,
    input  logic                      reset_i,
    input  logic                      flush_i,
    input  logic                      accept_i,
    input  logic                      emit0_i,
    input  logic                      emit1_i,
    input  logic                      hold_load_i,
    input  realign_pkg::slot_sel_e    slot0_sel_i,
    input  realign_pkg::addr_t        fetch_addr_i,
    input  realign_pkg::fetch_word_t  fetch_data_i,
    input  realign_pkg::parcel_t      parcel_lo_i,
    input  realign_pkg::parcel_t      parcel_hi_i,
    output logic                      valid0_o,
    output logic                      valid1_o,
    output realign_pkg::instr_t       instr0_o,
    output realign_pkg::instr_t       instr1_o,
    output realign_pkg::addr_t        addr0_o,
    output realign_pkg::addr_t        addr1_o
);

    localparam int unsigned PAD_W = `REALIGN_INSTR_WIDTH - 16;

    // pending lower half of a straddling instruction and where it started
    realign_pkg::parcel_t held_parcel_q;
    realign_pkg::addr_t   held_addr_q;

    realign_pkg::addr_t   upper_addr;
    realign_pkg::instr_t  slot0_instr;
    realign_pkg::addr_t   slot0_addr;
    realign_pkg::instr_t  slot1_instr;

    // output register, valids are control state and the rest is payload
    logic                 valid0_q;
    logic                 valid1_q;
    realign_pkg::instr_t  instr0_q;
    realign_pkg::instr_t  instr1_q;
    realign_pkg::addr_t   addr0_q;
    realign_pkg::addr_t   addr1_q;

    // ----------------------------------------------------------------------
    // slot formation
    // ----------------------------------------------------------------------

    // the upper parcel always lives at the word address plus 2
    assign upper_addr = {fetch_addr_i[`REALIGN_ADDR_WIDTH-1:2], 2'b10};

    always_comb begin
        slot0_instr = fetch_data_i;
        slot0_addr  = fetch_addr_i;
        case (slot0_sel_i)
            realign_pkg::SLOT_LOW_RVC: begin
                slot0_instr = {{PAD_W{1'b0}}, parcel_lo_i};
            end
            realign_pkg::SLOT_HIGH_RVC: begin
                // branch target on the upper halfword
                slot0_instr = {{PAD_W{1'b0}}, parcel_hi_i};
                slot0_addr  = upper_addr;
            end
            realign_pkg::SLOT_JOIN_HELD: begin
                // lower parcel completes the half held from the previous word
                slot0_instr = {parcel_lo_i, held_parcel_q};
                slot0_addr  = held_addr_q;
            end
            default: begin
                // full 32-bit word, taken as is at the fetch address
            end
        endcase
    end

    // slot 1 can only ever carry a compressed upper parcel
    assign slot1_instr = {{PAD_W{1'b0}}, parcel_hi_i};

    // ----------------------------------------------------------------------
    // held half
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        if (hold_load_i) begin
            held_parcel_q <= parcel_hi_i;
            held_addr_q   <= upper_addr;
        end
    end

    // ----------------------------------------------------------------------
    // output register
    // ----------------------------------------------------------------------

    // valids only live for the cycle after the word was taken
    always_ff @(posedge clk_i) begin
        if (reset_i || flush_i) begin
            valid0_q <= 1'b0;
            valid1_q <= 1'b0;
        end else begin
            valid0_q <= emit0_i;
            valid1_q <= emit1_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            instr0_q <= slot0_instr;
            addr0_q  <= slot0_addr;
            instr1_q <= slot1_instr;
            addr1_q  <= upper_addr;
        end
    end

    assign valid0_o = valid0_q;
    assign valid1_o = valid1_q;
    assign instr0_o = instr0_q;
    assign instr1_o = instr1_q;
    assign addr0_o  = addr0_q;
    assign addr1_o  = addr1_q;

endmodule

`default_nettype wire

// ==== logic/instr_realign_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "realign_config.svh"

module instr_realign_top (
    input  logic                            clk_i,
    input  logic                            reset_i,
    input  logic                            flush_i,
    input  logic                            fetch_valid_i,
    input  logic [`REALIGN_ADDR_WIDTH-1:0]  fetch_addr_i,
    input  logic [`REALIGN_FETCH_WIDTH-1:0] fetch_data_i,
    input  logic                            credit_i,
    output logic                            fetch_ready_o,
    output logic                            serving_unaligned_o,
    output logic                            valid0_o,
    output logic [`REALIGN_INSTR_WIDTH-1:0] instr0_o,
    output logic [`REALIGN_ADDR_WIDTH-1:0]  addr0_o,
    output logic                            valid1_o,
    output logic [`REALIGN_INSTR_WIDTH-1:0] instr1_o,
    output logic [`REALIGN_ADDR_WIDTH-1:0]  addr1_o
);

    // decoder results
    realign_pkg::parcel_t   parcel_lo;
    realign_pkg::parcel_t   parcel_hi;
    logic                   lo_is_rvc;
    logic                   hi_is_rvc;

    // control to datapath
    logic                   credit_ok;
    logic                   accept;
    logic                   emit0;
    logic                   emit1;
    logic                   hold_load;
    realign_pkg::slot_sel_e slot0_sel;

    parcel_decode parcel_decode_i (
        .fetch_data_i (fetch_data_i),
        .parcel_lo_o  (parcel_lo),
        .parcel_hi_o  (parcel_hi),
        .lo_is_rvc_o  (lo_is_rvc),
        .hi_is_rvc_o  (hi_is_rvc)
    );

    // bit 1 of the fetch address tells a branch into the upper halfword
    realign_ctrl realign_ctrl_i (
        .clk_i                (clk_i),
        .reset_i              (reset_i),
        .flush_i              (flush_i),
        .fetch_valid_i        (fetch_valid_i),
        .fetch_addr_hi_half_i (fetch_addr_i[1]),
        .lo_is_rvc_i          (lo_is_rvc),
        .hi_is_rvc_i          (hi_is_rvc),
        .credit_ok_i          (credit_ok),
        .fetch_ready_o        (fetch_ready_o),
        .accept_o             (accept),
        .emit0_o              (emit0),
        .emit1_o              (emit1),
        .hold_load_o          (hold_load),
        .slot0_sel_o          (slot0_sel),
        .serving_unaligned_o  (serving_unaligned_o)
    );

    // the emitted slots are exactly the queue entries spent
    credit_counter credit_counter_i (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .consume0_i  (emit0),
        .consume1_i  (emit1),
        .credit_i    (credit_i),
        .credit_ok_o (credit_ok)
    );

    instr_assemble instr_assemble_i (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .flush_i      (flush_i),
        .accept_i     (accept),
        .emit0_i      (emit0),
        .emit1_i      (emit1),
        .hold_load_i  (hold_load),
        .slot0_sel_i  (slot0_sel),
        .fetch_addr_i (fetch_addr_i),
        .fetch_data_i (fetch_data_i),
        .parcel_lo_i  (parcel_lo),
        .parcel_hi_i  (parcel_hi),
        .valid0_o     (valid0_o),
        .valid1_o     (valid1_o),
        .instr0_o     (instr0_o),
        .instr1_o     (instr1_o),
        .addr0_o      (addr0_o),
        .addr1_o      (addr1_o)
    );

endmodule

`default_nettype wire

// ==== sim/realign_model.svh ====
`ifndef REALIGN_MODEL_SVH
`define REALIGN_MODEL_SVH

// ----------------------------------------------------------------------
// random source
// ----------------------------------------------------------------------

// 32-bit Fibonacci LFSR, taps 32 22 2 1
logic [31:0] lfsr_q = 32'hff19;

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// the register moves once for every bit handed out
function logic [31:0] take_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_q = lfsr_next(lfsr_q);
        r = {r[30:0], lfsr_q[0]};
    end
    return r;
endfunction

// ----------------------------------------------------------------------
// reference model
// ----------------------------------------------------------------------

// model state, a lower half is pending while m_holding is set
logic                           m_holding;
logic [15:0]                    m_held_parcel;
logic [`REALIGN_ADDR_WIDTH-1:0] m_held_addr;
int                             m_credits;

// slots the DUT must show one cycle after the word was taken
logic                           exp_v0;
logic                           exp_v1;
logic [31:0]                    exp_i0;
logic [31:0]                    exp_i1;
logic [`REALIGN_ADDR_WIDTH-1:0] exp_a0;
logic [`REALIGN_ADDR_WIDTH-1:0] exp_a1;

// RISC-V rule, only 2'b11 in the low bits marks a 32-bit instruction
function automatic bit is_compressed(input logic [15:0] p);
    return p[1:0] != 2'b11;
endfunction

function void reset_model();
    m_holding = 1'b0;
    m_credits = `REALIGN_NUM_CREDITS;
    exp_v0    = 1'b0;
    exp_v1    = 1'b0;
endfunction

// applies the alignment rules to one accepted fetch word
function void predict_word(input logic [`REALIGN_ADDR_WIDTH-1:0] addr, input logic [31:0] data);
    logic [`REALIGN_ADDR_WIDTH-1:0] base;
    logic [15:0]                    p0;
    logic [15:0]                    p1;
    bit                             upper_left;
    base       = {addr[`REALIGN_ADDR_WIDTH-1:2], 2'b00};
    p0         = data[15:0];
    p1         = data[31:16];
    exp_v0     = 1'b0;
    exp_v1     = 1'b0;
    upper_left = 1'b0;
    if (m_holding) begin
        exp_v0     = 1'b1;
        exp_i0     = {p0, m_held_parcel};
        exp_a0     = m_held_addr;
        upper_left = 1'b1;
    end else if (addr[1]) begin
        // a branch into the upper half, p1 goes to slot 0 or is held
        if (is_compressed(p1)) begin
            exp_v0 = 1'b1;
            exp_i0 = {16'h0000, p1};
            exp_a0 = base + 2;
        end else begin
            m_holding     = 1'b1;
            m_held_parcel = p1;
            m_held_addr   = base + 2;
        end
    end else if (!is_compressed(p0)) begin
        exp_v0 = 1'b1;
        exp_i0 = data;
        exp_a0 = base;
    end else begin
        exp_v0     = 1'b1;
        exp_i0     = {16'h0000, p0};
        exp_a0     = base;
        upper_left = 1'b1;
    end
    // p1 after a slot 0 that ended at the middle of the word
    if (upper_left) begin
        if (is_compressed(p1)) begin
            exp_v1    = 1'b1;
            exp_i1    = {16'h0000, p1};
            exp_a1    = base + 2;
            m_holding = 1'b0;
        end else begin
            m_holding     = 1'b1;
            m_held_parcel = p1;
            m_held_addr   = base + 2;
        end
    end
endfunction

function void update_credits(input int used, input bit returned);
    m_credits = m_credits + int'(returned) - used;
    if (m_credits > `REALIGN_NUM_CREDITS) begin
        m_credits = `REALIGN_NUM_CREDITS;
    end
endfunction

// a word can yield two instructions, and flush blocks acceptance
function automatic bit ready_expected(input bit flush);
    return (m_credits >= 2) && !flush;
endfunction

`endif

// ==== sim/tb_instr_realign.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "realign_config.svh"

module tb_instr_realign;

    // words per test, the flush test sends two per round
    localparam int N_ALIGNED  = 200;
    localparam int N_STRADDLE = 100;
    localparam int N_BRANCH   = 100;
    localparam int N_FLUSH    = 20;
    localparam int N_CREDIT   = 100;
    localparam int TOTAL_WORDS = N_ALIGNED + N_STRADDLE + N_BRANCH + 2 * N_FLUSH + N_CREDIT;

    logic                            clk_i;
    logic                            reset_i;
    logic                            flush;
    logic                            fetch_valid;
    logic [`REALIGN_ADDR_WIDTH-1:0]  fetch_addr;
    logic [`REALIGN_FETCH_WIDTH-1:0] fetch_data;
    logic                            credit;
    logic                            fetch_ready;
    logic                            serving_unaligned;
    logic                            valid0;
    logic                            valid1;
    logic [`REALIGN_INSTR_WIDTH-1:0] instr0;
    logic [`REALIGN_INSTR_WIDTH-1:0] instr1;
    logic [`REALIGN_ADDR_WIDTH-1:0]  addr0;
    logic [`REALIGN_ADDR_WIDTH-1:0]  addr1;

    // bookkeeping of the run
    string current_test;
    int    errors;
    int    test_errors;
    int    checks;
    int    tests;
    int    cycle;
    bit    last_accept;
    bit    hold_credits;
    int    total_valid;
    int    total_returned;
    int    due_q[$];

    `include "realign_model.svh"

    instr_realign_top dut_i (
        .clk_i               (clk_i),
        .reset_i             (reset_i),
        .flush_i             (flush),
        .fetch_valid_i       (fetch_valid),
        .fetch_addr_i        (fetch_addr),
        .fetch_data_i        (fetch_data),
        .credit_i            (credit),
        .fetch_ready_o       (fetch_ready),
        .serving_unaligned_o (serving_unaligned),
        .valid0_o            (valid0),
        .instr0_o            (instr0),
        .addr0_o             (addr0),
        .valid1_o            (valid1),
        .instr1_o            (instr1),
        .addr1_o             (addr1)
    );

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    // generous bound, every word gets 20 clock periods
    initial begin
        #(TOTAL_WORDS * 20 * 20);
        $display("Timeout: the run did not finish within %0d ns", TOTAL_WORDS * 20 * 20);
        $display("Done: errors found");
        $finish;
    end

    // ----------------------------------------------------------------------
    // checking
    // ----------------------------------------------------------------------

    task check_value(input string what, input logic [31:0] expected, input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("Error: test %s, %s: expected %h, actual %h",
                     current_test, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task report_failure(input string text);
        $display("Test %s: %s", current_test, text);
        errors++;
        test_errors++;
    endtask

    // compares the output register with what the model predicted last cycle
    task check_slots();
        checks++;
        if (valid0 !== exp_v0) begin
            report_failure($sformatf("slot 0 valid is %b but the model expects %b", valid0, exp_v0));
        end else if (exp_v0) begin
            check_value("instr0", exp_i0, instr0);
            check_value("addr0", exp_a0, addr0);
        end
        if (valid1 !== exp_v1) begin
            report_failure($sformatf("slot 1 valid is %b but the model expects %b", valid1, exp_v1));
        end else if (exp_v1) begin
            check_value("instr1", exp_i1, instr1);
            check_value("addr1", exp_a1, addr1);
        end
        if (valid1 === 1'b1 && valid0 !== 1'b1) begin
            report_failure("slot 1 is valid while slot 0 is not");
        end
    endtask

    // the queue frees one entry a few random cycles after each instruction
    task schedule_return();
        int d;
        d = cycle + 1 + int'(take_bits(2));
        if (due_q.size() > 0 && d <= due_q[$]) begin
            d = due_q[$] + 1;
        end
        due_q.push_back(d);
    endtask

    // ----------------------------------------------------------------------
    // cycle engine
    // ----------------------------------------------------------------------

    // samples at the rising edge, then updates the model for the cycle that ended
    task step_cycle();
        bit ready_exp;
        int used;
        @(posedge clk_i);
        cycle++;
        check_slots();
        check_value("serving_unaligned", m_holding, serving_unaligned);
        ready_exp = ready_expected(flush);
        check_value("fetch_ready", ready_exp, fetch_ready);
        if (valid0 === 1'b1) begin
            total_valid++;
            schedule_return();
        end
        if (valid1 === 1'b1) begin
            total_valid++;
            schedule_return();
        end
        if (total_valid > total_returned + `REALIGN_NUM_CREDITS) begin
            report_failure("more instructions were issued than the queue has room for");
        end
        last_accept = fetch_valid && ready_exp;
        used = 0;
        if (flush) begin
            m_holding = 1'b0;
            exp_v0    = 1'b0;
            exp_v1    = 1'b0;
        end else if (last_accept) begin
            predict_word(fetch_addr, fetch_data);
            used = int'(exp_v0) + int'(exp_v1);
        end else begin
            exp_v0 = 1'b0;
            exp_v1 = 1'b0;
        end
        update_credits(used, credit);
        #2;
        if (!hold_credits && due_q.size() > 0 && due_q[0] <= cycle) begin
            void'(due_q.pop_front());
            credit = 1'b1;
            total_returned++;
        end else begin
            credit = 1'b0;
        end
    endtask

    task present_word(input logic [31:0] addr, input logic [31:0] data);
        fetch_valid = 1'b1;
        fetch_addr  = addr;
        fetch_data  = data;
    endtask

    // the word stays at the input until the DUT takes it
    task send_word(input logic [31:0] addr, input logic [31:0] data);
        present_word(addr, data);
        do begin
            step_cycle();
        end while (!last_accept);
        fetch_valid = 1'b0;
    endtask

    function automatic logic [31:0] aligned_addr();
        logic [31:0] r;
        r = take_bits(30);
        return {r[29:0], 2'b00};
    endfunction

    task start_test(input string name);
        current_test = name;
        test_errors  = 0;
        tests++;
    endtask

    task finish_test();
        $display("Test %s finished with %0d errors", current_test, test_errors);
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------

    initial begin
        logic [31:0] data;
        logic [31:0] addr;
        flush        = 1'b0;
        fetch_valid  = 1'b0;
        fetch_addr   = '0;
        fetch_data   = '0;
        credit       = 1'b0;
        hold_credits = 1'b0;
        errors       = 0;
        checks       = 0;
        tests        = 0;
        cycle        = 0;
        reset_i      = 1'b1;
        reset_model();
        repeat (4) @(posedge clk_i);
        #2;
        reset_i = 1'b0;

        start_test("aligned");
        for (int i = 0; i < N_ALIGNED; i++) begin
            if (take_bits(2) == 0) begin
                step_cycle();
            end
            send_word(aligned_addr(), take_bits(32));
        end
        finish_test();

        // p1 is always a lower half, p0 compressed whenever nothing is held
        start_test("straddle");
        for (int i = 0; i < N_STRADDLE; i++) begin
            data = take_bits(32);
            data[17:16] = 2'b11;
            if (!m_holding) begin
                data[0] = 1'b0;
            end
            send_word(aligned_addr(), data);
        end
        finish_test();

        start_test("branch_upper");
        for (int i = 0; i < N_BRANCH; i++) begin
            addr = aligned_addr();
            addr[1] = !m_holding;
            send_word(addr, take_bits(32));
        end
        finish_test();

        start_test("flush");
        for (int i = 0; i < N_FLUSH; i++) begin
            data = take_bits(32);
            data[17:16] = 2'b11;
            data[0] = 1'b0;
            send_word(aligned_addr(), data);
            // a word offered during the flush must be ignored
            flush = 1'b1;
            present_word(aligned_addr(), take_bits(32));
            step_cycle();
            flush       = 1'b0;
            fetch_valid = 1'b0;
            step_cycle();
            check_value("serving_unaligned after flush", 1'b0, serving_unaligned);
            send_word(aligned_addr(), take_bits(32));
        end
        finish_test();

        // stretches without credit returns stall the input
        start_test("credit");
        for (int i = 0; i < N_CREDIT; i++) begin
            hold_credits = 1'b1;
            present_word(aligned_addr(), take_bits(32));
            repeat (int'(take_bits(3))) begin
                step_cycle();
                if (last_accept) begin
                    present_word(aligned_addr(), take_bits(32));
                end
            end
            hold_credits = 1'b0;
            send_word(fetch_addr, fetch_data);
        end
        finish_test();

        // let the last outputs reach the checker
        repeat (2) step_cycle();

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+logic
+incdir+sim
logic/realign_pkg.sv
logic/parcel_decode.sv
logic/credit_counter.sv
logic/realign_ctrl.sv
logic/instr_assemble.sv
logic/instr_realign_top.sv
sim/tb_instr_realign.sv

// ==== Bender.yml ====
package:
  name: instr_realign

sources:
  - include_dirs:
      - logic
    files:
      - logic/realign_pkg.sv
      - logic/parcel_decode.sv
      - logic/credit_counter.sv
      - logic/realign_ctrl.sv
      - logic/instr_assemble.sv
      - logic/instr_realign_top.sv
  - target: simulation
    include_dirs:
      - logic
      - sim
    files:
      - sim/tb_instr_realign.sv
